/* project.f */
verilog/led_matrix_pkg.sv
verilog/fb_bus_if.sv
verilog/frame_loader.sv
verilog/framebuffer_fetch.sv
verilog/framebuffer.sv
verilog/matrix_scan.sv
verilog/led_matrix_top.sv
testbench/tb_panel_capture.sv
testbench/tb_led_matrix.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_led_matrix
FILELIST  = project.f
BUILD_DIR = obj_dir
PASS_MSG  = Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* testbench/tb_led_matrix.sv */
`timescale 1ns/10ps

module tb_led_matrix;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int STROBE_GAP   = 8;
    localparam int TEST_COUNT   = 5;
    localparam int ROWS_PER_SCAN = led_matrix_pkg::PIXEL_HALFHEIGHT * led_matrix_pkg::PLANES;
    // About 8 cycles per column plus blank, latch and weighted hold
    localparam int SCAN_CYCLES = led_matrix_pkg::PIXEL_HALFHEIGHT
        * (led_matrix_pkg::PLANES * (led_matrix_pkg::PIXEL_WIDTH * 8 + 4)
           + led_matrix_pkg::HOLD_BASE * ((1 << led_matrix_pkg::PLANES) - 1));
    localparam int LOAD_CYCLES = (led_matrix_pkg::FB_BYTES + 8) * STROBE_GAP;
    localparam int WATCHDOG_CYCLES = TEST_COUNT * (5 * SCAN_CYCLES + LOAD_CYCLES)
                                     + 2 * RESET_CYCLES;

    logic       clk_in;
    logic       arst_n;
    logic [7:0] rx_data;
    logic       rx_strobe;
    logic [2:0] rgb1;
    logic [2:0] rgb2;
    logic [3:0] row_address;
    logic       clk_pixel;
    logic       row_latch;
    logic       output_enable_n;

    logic                                     check_en;
    logic [led_matrix_pkg::PIXEL_WIDTH*3-1:0] exp_top;
    logic [led_matrix_pkg::PIXEL_WIDTH*3-1:0] exp_bottom;
    logic [led_matrix_pkg::ROW_W-1:0]         cur_row;
    logic [2:0]                               cur_plane;
    int                                       rows_checked;
    int                                       capture_errors;

    // Testbench copy of the frame and the settings
    logic [7:0]                        image [led_matrix_pkg::FB_BYTES];
    logic [2:0]                        model_rgb_en;
    logic [led_matrix_pkg::PLANES-1:0] model_bright_en;
    logic [15:0]                       lfsr_state;
    int tb_errors;
    int passed;
    int failed;

    led_matrix_top uut (
        .clk_in          (clk_in),
        .arst_n          (arst_n),
        .rx_data         (rx_data),
        .rx_strobe       (rx_strobe),
        .rgb1            (rgb1),
        .rgb2            (rgb2),
        .row_address     (row_address),
        .clk_pixel       (clk_pixel),
        .row_latch       (row_latch),
        .output_enable_n (output_enable_n)
    );

    tb_panel_capture panel (
        .clk_in          (clk_in),
        .arst_n          (arst_n),
        .rgb1            (rgb1),
        .rgb2            (rgb2),
        .row_address     (row_address),
        .clk_pixel       (clk_pixel),
        .row_latch       (row_latch),
        .output_enable_n (output_enable_n),
        .check_en        (check_en),
        .exp_top         (exp_top),
        .exp_bottom      (exp_bottom),
        .cur_row         (cur_row),
        .cur_plane       (cur_plane),
        .rows_checked    (rows_checked),
        .error_count     (capture_errors)
    );

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 16'hB400;
        return n;
    endfunction

    // Pixel split rule, red at bit 0
    function automatic logic [2:0] expected_bits(input logic [15:0] pixel, input int plane,
                                                 input logic [2:0] rgb_en,
                                                 input logic [5:0] bright_en);
        logic [5:0] red;
        logic [5:0] green;
        logic [5:0] blue;
        logic [2:0] bits;
        red     = {pixel[15:11], pixel[15]};
        green   = pixel[10:5];
        blue    = {pixel[4:0], pixel[4]};
        bits[0] = red[plane] & rgb_en[0] & bright_en[plane];
        bits[1] = green[plane] & rgb_en[1] & bright_en[plane];
        bits[2] = blue[plane] & rgb_en[2] & bright_en[plane];
        return bits;
    endfunction

    function automatic logic [15:0] pixel_word(input int row, input int col);
        logic [7:0] addr;
        addr = 8'((row * led_matrix_pkg::PIXEL_WIDTH + col) * led_matrix_pkg::BYTES_PER_PIXEL);
        return {image[addr], image[addr + 8'd1]}; // High byte first
    endfunction

    // Expected columns of the row and plane the panel model waits for
    always_comb begin
        for (int c = 0; c < led_matrix_pkg::PIXEL_WIDTH; c++) begin
            exp_top[c*3 +: 3] = expected_bits(pixel_word(int'(cur_row), c), int'(cur_plane),
                                              model_rgb_en, model_bright_en);
            exp_bottom[c*3 +: 3] = expected_bits(
                pixel_word(int'(cur_row) + led_matrix_pkg::PIXEL_HALFHEIGHT, c),
                int'(cur_plane), model_rgb_en, model_bright_en);
        end
    end

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk_in);
        rx_data   <= b;
        rx_strobe <= 1'b1;
        @(posedge clk_in);
        rx_strobe <= 1'b0;
        repeat (STROBE_GAP - 2) @(posedge clk_in);
    endtask

    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b[i]       = lfsr_state[0];
        end
    endtask

    task automatic load_frame(input logic use_random);
        logic [7:0] b;
        send_byte(led_matrix_pkg::CMD_WRITE_FRAME);
        for (int i = 0; i < led_matrix_pkg::FB_BYTES; i++) begin
            if (use_random) random_byte(b);
            else b = 8'h00;
            image[i] = b;
            send_byte(b);
        end
    endtask

    task automatic set_rgb_enable(input logic [2:0] v);
        send_byte(led_matrix_pkg::CMD_SET_RGB_ENABLE);
        send_byte({5'b11111, v}); // Upper bits are dropped
        model_rgb_en = v;
    endtask

    task automatic set_brightness(input logic [5:0] v);
        send_byte(led_matrix_pkg::CMD_SET_BRIGHTNESS);
        send_byte({2'b11, v});
        model_bright_en = v;
    endtask

    // One full scan of every row and plane against the reference
    task automatic scan_and_check();
        int target;
        @(posedge clk_in);
        check_en <= 1'b1;
        target = rows_checked + ROWS_PER_SCAN;
        while (rows_checked < target) @(posedge clk_in);
        check_en <= 1'b0;
    endtask

    task automatic check_idle_outputs();
        if (clk_pixel !== 1'b0 || row_latch !== 1'b0) begin
            $display("Fail at %0t: clk_pixel/row_latch expected 0/0 actual %b/%b",
                     $time, clk_pixel, row_latch);
            tb_errors++;
        end
        if (rgb1 !== 3'b000 || rgb2 !== 3'b000) begin
            $display("Fail at %0t: rgb1/rgb2 expected 000/000 actual %b/%b", $time, rgb1, rgb2);
            tb_errors++;
        end
        if (output_enable_n !== 1'b1) begin
            $display("Fail at %0t: output_enable_n expected 1 actual %b", $time, output_enable_n);
            tb_errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        int errs;
        errs = tb_errors + capture_errors - errs_before;
        if (errs == 0) passed++;
        else failed++;
        $display("Test %0d %s: %0d errors", num, name, errs);
    endtask

    initial begin
        int errs_before;
        clk_in          = 1'b0;
        arst_n          = 1'b0;
        rx_data         = 8'h00;
        rx_strobe       = 1'b0;
        check_en        = 1'b0;
        lfsr_state      = 16'd43059;
        model_rgb_en    = '1;
        model_bright_en = '1;
        tb_errors       = 0;
        passed          = 0;
        failed          = 0;

        errs_before = 0;
        repeat (RESET_CYCLES) begin
            @(negedge clk_in);
            check_idle_outputs();
        end
        @(posedge clk_in);
        arst_n <= 1'b1;
        @(negedge clk_in);
        check_idle_outputs(); // Right after release
        load_frame(1'b0);
        scan_and_check();
        report_test(1, "reset state and blank frame", errs_before);

        errs_before = tb_errors + capture_errors;
        send_byte(8'h7E); // Unknown opcodes
        send_byte(8'hC4);
        load_frame(1'b1);
        scan_and_check();
        report_test(2, "random frame", errs_before);

        errs_before = tb_errors + capture_errors;
        set_rgb_enable(3'b101);
        scan_and_check();
        report_test(3, "green channel disabled", errs_before);

        errs_before = tb_errors + capture_errors;
        set_rgb_enable(3'b111);
        set_brightness(6'b101010);
        scan_and_check();
        report_test(4, "even planes disabled", errs_before);

        errs_before = tb_errors + capture_errors;
        set_brightness(6'b111111);
        scan_and_check(); // Hold times and row order checked on every latch
        report_test(5, "plane hold and row order", errs_before);

        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 passed, failed, tb_errors + capture_errors);
        if (failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

/* testbench/tb_panel_capture.sv */
`timescale 1ns/10ps

module tb_panel_capture (
    input  logic                                     clk_in,
    input  logic                                     arst_n,
    input  logic [2:0]                               rgb1,
    input  logic [2:0]                               rgb2,
    input  logic [3:0]                               row_address,
    input  logic                                     clk_pixel,
    input  logic                                     row_latch,
    input  logic                                     output_enable_n,
    input  logic                                     check_en,
    input  logic [led_matrix_pkg::PIXEL_WIDTH*3-1:0] exp_top,
    input  logic [led_matrix_pkg::PIXEL_WIDTH*3-1:0] exp_bottom,
    output logic [led_matrix_pkg::ROW_W-1:0]         cur_row,
    output logic [2:0]                               cur_plane,
    output int                                       rows_checked,
    output int                                       error_count
);

    logic [2:0] cap_top [led_matrix_pkg::PIXEL_WIDTH];
    logic [2:0] cap_bottom [led_matrix_pkg::PIXEL_WIDTH];
    int   col_idx;
    logic armed;      // Row started while checking was on
    logic measuring;  // Counting the low time of output_enable_n
    logic hold_armed;
    int   low_cycles;
    int   hold_expected;

    task automatic compare_row();
        if (col_idx != led_matrix_pkg::PIXEL_WIDTH) begin
            $display("Fail at %0t: clk_pixel pulses expected %0d actual %0d",
                     $time, led_matrix_pkg::PIXEL_WIDTH, col_idx);
            error_count++;
        end
        if (row_address !== {{(4 - led_matrix_pkg::ROW_W){1'b0}}, cur_row}) begin
            $display("Fail at %0t: row_address expected %0d actual %0d",
                     $time, cur_row, row_address);
            error_count++;
        end
        for (int c = 0; c < led_matrix_pkg::PIXEL_WIDTH; c++) begin
            if (cap_top[c] !== exp_top[c*3 +: 3]) begin
                $display("Fail at %0t: rgb1 row %0d plane %0d column %0d expected %b actual %b",
                         $time, cur_row, cur_plane, c, exp_top[c*3 +: 3], cap_top[c]);
                error_count++;
            end
            if (cap_bottom[c] !== exp_bottom[c*3 +: 3]) begin
                $display("Fail at %0t: rgb2 row %0d plane %0d column %0d expected %b actual %b",
                         $time, cur_row, cur_plane, c, exp_bottom[c*3 +: 3], cap_bottom[c]);
                error_count++;
            end
        end
    endtask

    // Outputs change on the rising edge, so the falling edge sees them settled
    always @(negedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            col_idx       = 0;
            armed         = 1'b0;
            measuring     = 1'b0;
            hold_armed    = 1'b0;
            low_cycles    = 0;
            hold_expected = 0;
            cur_row       = '0;
            cur_plane     = '0;
            rows_checked  = 0;
            error_count   = 0;
        end else begin
            // Hold of the previous latch ends when output_enable_n rises
            if (measuring) begin
                if (!output_enable_n) begin
                    low_cycles++;
                end else begin
                    measuring = 1'b0;
                    if (hold_armed) begin
                        if (low_cycles != hold_expected) begin
                            $display("Fail at %0t: output_enable_n low cycles expected %0d actual %0d",
                                     $time, hold_expected, low_cycles);
                            error_count++;
                        end
                        rows_checked++;
                    end
                end
            end
            if (clk_pixel) begin
                if (col_idx == 0) armed = check_en;
                if (col_idx < led_matrix_pkg::PIXEL_WIDTH) begin
                    cap_top[col_idx]    = rgb1;
                    cap_bottom[col_idx] = rgb2;
                end
                col_idx++;
            end
            if (row_latch) begin
                if (armed && check_en) compare_row();
                hold_armed    = armed && check_en;
                hold_expected = led_matrix_pkg::HOLD_BASE << cur_plane;
                measuring     = 1'b1;
                low_cycles    = 0;
                col_idx       = 0;
                armed         = 1'b0;
                if (int'(cur_plane) == led_matrix_pkg::PLANES - 1) begin
                    cur_plane = '0;
                    cur_row   = cur_row + 1'b1; // Wraps after the last half row
                end else begin
                    cur_plane = cur_plane + 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/led_matrix_top.sv */
`timescale 1ns/10ps

module led_matrix_top (
    input  logic       clk_in,
    input  logic       arst_n,
    input  logic [7:0] rx_data,
    input  logic       rx_strobe,
    output logic [2:0] rgb1,        // Top half, red at bit 0
    output logic [2:0] rgb2,        // Bottom half
    output logic [3:0] row_address,
    output logic       clk_pixel,
    output logic       row_latch,
    output logic       output_enable_n
);

    logic [2:0]                        rgb_enable;
    logic [led_matrix_pkg::PLANES-1:0] brightness_enable;
    logic                              load_start;
    logic [led_matrix_pkg::COL_W-1:0]  column;
    logic [led_matrix_pkg::ROW_W-1:0]  row;
    logic [15:0]                       rgb565_top;
    logic [15:0]                       rgb565_bottom;
    logic                              pixel_ready;

    fb_bus_if fetch_bus ();
    fb_bus_if load_bus ();

    frame_loader u_loader (
        .clk_in            (clk_in),
        .arst_n            (arst_n),
        .rx_data           (rx_data),
        .rx_strobe         (rx_strobe),
        .bus               (load_bus),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    framebuffer_fetch u_fetch (
        .clk_in        (clk_in),
        .arst_n        (arst_n),
        .load_start    (load_start),
        .column        (column),
        .row           (row),
        .bus           (fetch_bus),
        .rgb565_top    (rgb565_top),
        .rgb565_bottom (rgb565_bottom),
        .pixel_ready   (pixel_ready)
    );

    framebuffer u_fb (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .fetch_port (fetch_bus),
        .load_port  (load_bus)
    );

    matrix_scan u_scan (
        .clk_in            (clk_in),
        .arst_n            (arst_n),
        .rgb565_top        (rgb565_top),
        .rgb565_bottom     (rgb565_bottom),
        .pixel_ready       (pixel_ready),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .load_start        (load_start),
        .column            (column),
        .row               (row),
        .rgb1              (rgb1),
        .rgb2              (rgb2),
        .row_address       (row_address),
        .clk_pixel         (clk_pixel),
        .row_latch         (row_latch),
        .output_enable_n   (output_enable_n)
    );

endmodule

/* verilog/matrix_scan.sv */
`timescale 1ns/10ps

module matrix_scan (
    input  logic                              clk_in,
    input  logic                              arst_n,
    input  logic [15:0]                       rgb565_top,
    input  logic [15:0]                       rgb565_bottom,
    input  logic                              pixel_ready,
    input  logic [2:0]                        rgb_enable,
    input  logic [led_matrix_pkg::PLANES-1:0] brightness_enable,
    output logic                              load_start,
    output logic [led_matrix_pkg::COL_W-1:0]  column,
    output logic [led_matrix_pkg::ROW_W-1:0]  row,
    output logic [2:0]                        rgb1,
    output logic [2:0]                        rgb2,
    output logic [3:0]                        row_address,
    output logic                              clk_pixel,
    output logic                              row_latch,
    output logic                              output_enable_n
);

    led_matrix_pkg::scan_state_e state;

    logic [$clog2(led_matrix_pkg::PLANES)-1:0] plane;
    logic waiting; // load_start sent, pair not back yet
    logic [$clog2(led_matrix_pkg::HOLD_BASE)+led_matrix_pkg::PLANES-1:0] hold_cnt;
    int unsigned hold_len;

    // Red and blue widened to 6 bits with their own MSB
    function automatic logic [2:0] split_pixel(input logic [15:0] px,
                                               input logic [$clog2(led_matrix_pkg::PLANES)-1:0] pl);
        logic [5:0] red;
        logic [5:0] green;
        logic [5:0] blue;
        red   = {px[15:11], px[15]};
        green = px[10:5];
        blue  = {px[4:0], px[4]};
        split_pixel = {blue[pl], green[pl], red[pl]}
                      & {3{brightness_enable[pl]}} & rgb_enable;
    endfunction

    assign hold_len = led_matrix_pkg::HOLD_BASE << plane; // Binary weighted

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state           <= led_matrix_pkg::SCAN_FETCH;
            waiting         <= 1'b0;
            load_start      <= 1'b0;
            column          <= '0;
            row             <= '0;
            plane           <= '0;
            hold_cnt        <= '0;
            rgb1            <= '0;
            rgb2            <= '0;
            row_address     <= '0;
            clk_pixel       <= 1'b0;
            row_latch       <= 1'b0;
            output_enable_n <= 1'b1;
        end else begin
            load_start <= 1'b0;
            clk_pixel  <= 1'b0;
            row_latch  <= 1'b0;
            case (state)
                led_matrix_pkg::SCAN_FETCH: begin
                    if (!waiting) begin
                        load_start <= 1'b1;
                        waiting    <= 1'b1;
                    end else if (pixel_ready) begin
                        rgb1    <= split_pixel(rgb565_top, plane);
                        rgb2    <= split_pixel(rgb565_bottom, plane);
                        waiting <= 1'b0;
                        state   <= led_matrix_pkg::SCAN_SHIFT;
                    end
                end
                led_matrix_pkg::SCAN_SHIFT: begin
                    // Data already stable, rising edge next cycle
                    clk_pixel <= 1'b1;
                    column    <= column + 1'b1;
                    state     <= (&column) ? led_matrix_pkg::SCAN_BLANK
                                           : led_matrix_pkg::SCAN_FETCH;
                end
                led_matrix_pkg::SCAN_BLANK: begin
                    output_enable_n <= 1'b1;
                    row_address     <= {{(4 - led_matrix_pkg::ROW_W){1'b0}}, row};
                    state           <= led_matrix_pkg::SCAN_LATCH;
                end
                led_matrix_pkg::SCAN_LATCH: begin
                    row_latch <= 1'b1;
                    hold_cnt  <= hold_len[$bits(hold_cnt)-1:0];
                    state     <= led_matrix_pkg::SCAN_DISPLAY;
                end
                default: begin
                    if (hold_cnt != '0) begin
                        output_enable_n <= 1'b0;
                        hold_cnt        <= hold_cnt - 1'b1;
                    end else begin
                        output_enable_n <= 1'b1;
                        state           <= led_matrix_pkg::SCAN_FETCH;
                        if (int'(plane) == led_matrix_pkg::PLANES - 1) begin
                            plane <= '0;
                            row   <= row + 1'b1; // Wraps after the last half row
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* verilog/framebuffer.sv */
`timescale 1ns/10ps

module framebuffer (
    input  logic     clk_in,
    input  logic     arst_n,
    fb_bus_if.memory fetch_port,
    fb_bus_if.memory load_port
);

    logic [7:0] mem [led_matrix_pkg::FB_BYTES];
    logic [7:0] rdata_q;

    // Selected access for this cycle
    logic                                 acc_req;
    logic [led_matrix_pkg::FB_ADDR_W-1:0] acc_addr;
    logic                                 acc_we;
    logic [7:0]                           acc_wdata;

    // Fixed priority, the scanner cannot be stalled
    assign fetch_port.gnt = fetch_port.req;
    assign load_port.gnt  = load_port.req & ~fetch_port.req;

    always_comb begin
        if (fetch_port.req) begin
            acc_req   = 1'b1;
            acc_addr  = fetch_port.addr;
            acc_we    = fetch_port.we;
            acc_wdata = fetch_port.wdata;
        end else begin
            acc_req   = load_port.req;
            acc_addr  = load_port.addr;
            acc_we    = load_port.we;
            acc_wdata = load_port.wdata;
        end
    end

    // Single port, one access per cycle
    always_ff @(posedge clk_in) begin
        if (acc_req) begin
            if (acc_we) begin
                mem[acc_addr] <= acc_wdata;
            end else begin
                rdata_q <= mem[acc_addr];
            end
        end
    end

    // Both ports see the same read register
    assign fetch_port.rdata = rdata_q;
    assign load_port.rdata  = rdata_q;

    // Loader waits out at most one fetch burst
    assert property (@(posedge clk_in) disable iff (!arst_n)
        load_port.req |-> ##[0:4] load_port.gnt);

endmodule

/* verilog/framebuffer_fetch.sv */
`timescale 1ns/10ps

module framebuffer_fetch (
    input  logic                             clk_in,
    input  logic                             arst_n,
    input  logic                             load_start,
    input  logic [led_matrix_pkg::COL_W-1:0] column,
    input  logic [led_matrix_pkg::ROW_W-1:0] row,
    fb_bus_if.requester                      bus,
    output logic [15:0]                      rgb565_top,
    output logic [15:0]                      rgb565_bottom,
    output logic                             pixel_ready
);

    logic [led_matrix_pkg::FB_ADDR_W-1:0] top_addr;
    logic [led_matrix_pkg::FB_ADDR_W-1:0] bottom_addr;
    logic       busy;
    logic [1:0] rd_idx;   // 0 top high, 1 top low, 2 bottom high, 3 bottom low
    logic       rd_valid;
    logic [1:0] rd_sel;   // Which byte comes back on rdata

    // Byte addresses of both pixels, bottom half is HALFHEIGHT rows further down
    always_comb begin
        int unsigned top_lin;
        int unsigned bottom_lin;
        top_lin = (int'(row) * led_matrix_pkg::PIXEL_WIDTH + int'(column))
                  * led_matrix_pkg::BYTES_PER_PIXEL;
        bottom_lin = ((int'(row) + led_matrix_pkg::PIXEL_HALFHEIGHT)
                      * led_matrix_pkg::PIXEL_WIDTH + int'(column))
                     * led_matrix_pkg::BYTES_PER_PIXEL;
        top_addr    = top_lin[led_matrix_pkg::FB_ADDR_W-1:0];
        bottom_addr = bottom_lin[led_matrix_pkg::FB_ADDR_W-1:0];
    end

    // First read goes out in the load_start cycle itself
    assign bus.req   = load_start | busy;
    assign bus.addr  = (rd_idx[1] ? bottom_addr : top_addr)
                     | {{(led_matrix_pkg::FB_ADDR_W-1){1'b0}}, rd_idx[0]};
    assign bus.we    = 1'b0;
    assign bus.wdata = '0;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            busy        <= 1'b0;
            rd_idx      <= '0;
            rd_valid    <= 1'b0;
            rd_sel      <= '0;
            pixel_ready <= 1'b0;
        end else begin
            if (bus.gnt) begin
                rd_idx <= rd_idx + 1'b1;
                busy   <= (rd_idx != 2'd3);
            end
            rd_valid    <= bus.gnt;
            rd_sel      <= rd_idx;
            pixel_ready <= rd_valid && rd_sel == 2'd3;
        end
    end

    // Word assembly
    always_ff @(posedge clk_in) begin
        if (rd_valid) begin
            case (rd_sel)
                2'd0: rgb565_top[15:8]   <= bus.rdata;
                2'd1: rgb565_top[7:0]    <= bus.rdata;
                2'd2: rgb565_bottom[15:8] <= bus.rdata;
                default: rgb565_bottom[7:0] <= bus.rdata;
            endcase
        end
    end

    // Fetch wins every arbitration, so the pair is always back in 5 cycles
    assert property (@(posedge clk_in) disable iff (!arst_n)
        load_start |-> ##5 pixel_ready);

endmodule

/* verilog/frame_loader.sv */
`timescale 1ns/10ps

module frame_loader (
    input  logic                              clk_in,
    input  logic                              arst_n,
    input  logic [7:0]                        rx_data,
    input  logic                              rx_strobe,
    fb_bus_if.requester                       bus,
    output logic [2:0]                        rgb_enable,
    output logic [led_matrix_pkg::PLANES-1:0] brightness_enable
);

    led_matrix_pkg::load_state_e state;
    led_matrix_pkg::cmd_e cmd;

    logic [led_matrix_pkg::FB_ADDR_W-1:0] count;     // Next frame address
    logic                                 pending;
    logic [led_matrix_pkg::FB_ADDR_W-1:0] pend_addr;
    logic [7:0]                           pend_data;

    assign cmd = led_matrix_pkg::cmd_e'(rx_data);

    // Pending byte stays on the bus until granted
    assign bus.req   = pending;
    assign bus.addr  = pend_addr;
    assign bus.we    = 1'b1; // Write only port
    assign bus.wdata = pend_data;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state             <= led_matrix_pkg::LOAD_IDLE;
            count             <= '0;
            pending           <= 1'b0;
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else begin
            if (bus.gnt) pending <= 1'b0;
            if (rx_strobe) begin
                case (state)
                    led_matrix_pkg::LOAD_IDLE: begin
                        case (cmd)
                            led_matrix_pkg::CMD_WRITE_FRAME: begin
                                count <= '0;
                                state <= led_matrix_pkg::LOAD_FRAME;
                            end
                            led_matrix_pkg::CMD_SET_RGB_ENABLE: state <= led_matrix_pkg::LOAD_RGB_ARG;
                            led_matrix_pkg::CMD_SET_BRIGHTNESS:
                                state <= led_matrix_pkg::LOAD_BRIGHT_ARG;
                            default: ; // Unknown opcode dropped
                        endcase
                    end
                    led_matrix_pkg::LOAD_FRAME: begin
                        pending <= 1'b1;
                        count   <= count + 1'b1;
                        if (&count) state <= led_matrix_pkg::LOAD_IDLE; // Last byte of the frame
                    end
                    led_matrix_pkg::LOAD_RGB_ARG: begin
                        rgb_enable <= rx_data[2:0];
                        state      <= led_matrix_pkg::LOAD_IDLE;
                    end
                    default: begin
                        brightness_enable <= rx_data[led_matrix_pkg::PLANES-1:0];
                        state             <= led_matrix_pkg::LOAD_IDLE;
                    end
                endcase
            end
        end
    end

    // Payload of the pending write
    always_ff @(posedge clk_in) begin
        if (rx_strobe && state == led_matrix_pkg::LOAD_FRAME) begin
            pend_addr <= count;
            pend_data <= rx_data;
        end
    end

    // Upstream receiver spacing
    assert property (@(posedge clk_in) disable iff (!arst_n)
        rx_strobe |=> !rx_strobe [*5]);

    // Fetch priority must leave room for every frame byte
    assert property (@(posedge clk_in) disable iff (!arst_n)
        rx_strobe |-> !pending);

endmodule

/* verilog/fb_bus_if.sv */
`timescale 1ns/10ps

// One requester port onto the single-port framebuffer
interface fb_bus_if;
    logic                                req;
    logic                                gnt;   // Combinational from the arbiter
    logic [led_matrix_pkg::FB_ADDR_W-1:0] addr;
    logic                                we;
    logic [7:0]                          wdata;
    logic [7:0]                          rdata; // Valid one cycle after the grant

    modport requester (
        output req,
        output addr,
        output we,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport memory (
        input  req,
        input  addr,
        input  we,
        input  wdata,
        output gnt,
        output rdata
    );
endinterface

/* verilog/led_matrix_pkg.sv */
package led_matrix_pkg;

    // Panel geometry, two halves scanned together
    localparam int PIXEL_WIDTH      = 16;
    localparam int PIXEL_HEIGHT     = 8;
    localparam int PIXEL_HALFHEIGHT = 4;
    localparam int BYTES_PER_PIXEL  = 2; // RGB565, high byte first

    // Framebuffer size and address widths
    localparam int FB_BYTES  = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL;
    localparam int FB_ADDR_W = $clog2(FB_BYTES);
    localparam int COL_W     = $clog2(PIXEL_WIDTH);
    localparam int ROW_W     = $clog2(PIXEL_HALFHEIGHT);

    // Brightness bit planes
    localparam int PLANES    = 6;
    // Plane b is lit for HOLD_BASE << b cycles
    localparam int HOLD_BASE = 8;

    // Opcodes of the byte stream
    typedef enum logic [7:0] {
        CMD_WRITE_FRAME    = 8'd1,
        CMD_SET_RGB_ENABLE = 8'd2,
        CMD_SET_BRIGHTNESS = 8'd3
    } cmd_e;

    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_FRAME,       // Counting frame bytes
        LOAD_RGB_ARG,
        LOAD_BRIGHT_ARG
    } load_state_e;

    typedef enum logic [2:0] {
        SCAN_FETCH,   // Ask for a pixel pair and wait
        SCAN_SHIFT,   // Clock one column into the panel
        SCAN_BLANK,
        SCAN_LATCH,
        SCAN_DISPLAY  // Weighted on time of the plane
    } scan_state_e;

endpackage
